// ==== lsu_top.f ====
src/lsu_pkg.sv
src/mem_stage.sv
src/wait_timer.sv
src/apb_master_fsm.sv
src/data_ram.sv
src/lsu_top.sv
testbench/tb_lsu_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the lsu_top testbench with Verilator
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f lsu_top.f --top-module tb_lsu_top -o sim_lsu_top && \
./obj_dir/sim_lsu_top || { echo "lsu_top simulation did not pass"; exit 1; }

// ==== testbench/tb_lsu_top.sv ====
`timescale 1ns/1ps

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_OPS        = 300;
    // Each random op may add a follow-up load, plus the reset load
    localparam int N_REQS       = 2 * N_OPS + 1;
    localparam int WATCHDOG_NS  = N_REQS * (MEM_WAIT_STATES + 8) * CLK_PERIOD
                                  + (RESET_CYCLES + 2) * CLK_PERIOD;
    localparam int MODEL_AW     = MEM_INDEX_W + 2;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic              mem_read;
    logic              mem_write;
    logic              is_signed;
    access_size_e      inst_size;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] write_data;
    logic              req_ready;
    logic              resp_valid;
    logic [DATA_W-1:0] read_data;
    logic              resp_error;

    // Byte-wide model of the RAM
    logic [7:0]        model_mem [1 << MODEL_AW];
    logic [DATA_W-1:0] last_read;
    integer            seed;
    int                reqs_done;

    lsu_top u_lsu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .is_signed  (is_signed),
        .inst_size  (inst_size),
        .address    (address),
        .write_data (write_data),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .read_data  (read_data),
        .resp_error (resp_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error: time %0t signal %s expected %h actual %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("error: time %0t signal %s expected %b actual %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("error: time %0t signal %s expected %0d cycles actual %0d",
                                     $time, name, expected, actual));
        end
    endtask

    function automatic int size_bytes(input access_size_e size);
        case (size)
            ACCESS_BYTE: return 1;
            ACCESS_HALF: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic is_misaligned(input access_size_e size,
                                           input logic [ADDR_W-1:0] addr);
        case (size)
            ACCESS_BYTE: return 1'b0;
            ACCESS_HALF: return addr[0];
            default:     return addr[1:0] != 2'b00;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] model_load(input logic [ADDR_W-1:0] addr,
                                                     input access_size_e size,
                                                     input logic sgn);
        logic [MODEL_AW-1:0] base;
        logic [DATA_W-1:0]   value;
        int                  nbytes;
        base   = addr[MODEL_AW-1:0];
        nbytes = size_bytes(size);
        value  = '0;
        for (int k = 0; k < nbytes; k++) begin
            value[8*k +: 8] = model_mem[base + MODEL_AW'(k)];
        end
        if (sgn && nbytes == 1) begin
            value = {{(DATA_W - 8){value[7]}}, value[7:0]};
        end else if (sgn && nbytes == 2) begin
            value = {{(DATA_W - 16){value[15]}}, value[15:0]};
        end
        return value;
    endfunction

    task automatic model_store(input logic [ADDR_W-1:0] addr, input access_size_e size,
                               input logic [DATA_W-1:0] wdata);
        logic [MODEL_AW-1:0] base;
        int                  nbytes;
        base   = addr[MODEL_AW-1:0];
        nbytes = size_bytes(size);
        for (int k = 0; k < nbytes; k++) begin
            model_mem[base + MODEL_AW'(k)] = wdata[8*k +: 8];
        end
    endtask

    // Called right after a rising edge with the unit idle
    task automatic run_request(input logic is_write, input access_size_e size,
                               input logic sgn, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
        logic              misal;
        logic [DATA_W-1:0] exp_data;
        int                exp_lat;
        int                lat;
        misal   = is_misaligned(size, addr);
        exp_lat = misal ? 2 : MEM_WAIT_STATES + 3;
        if (!is_write && !misal) begin
            exp_data  = model_load(addr, size, sgn);
            last_read = exp_data;
        end else begin
            exp_data = last_read;
        end

        req_valid  <= 1'b1;
        mem_read   <= !is_write;
        mem_write  <= is_write;
        is_signed  <= sgn;
        inst_size  <= size;
        address    <= addr;
        write_data <= wdata;

        @(posedge clk);
        while (req_ready !== 1'b1) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;

        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            check_flag("req_ready", 1'b0, req_ready);
        end while (resp_valid !== 1'b1);

        check_latency("resp_valid", exp_lat, lat);
        check_flag("resp_error", misal, resp_error);
        check_data("read_data", exp_data, read_data);

        // Response is a single-cycle pulse and the unit is free again
        @(posedge clk);
        check_flag("resp_valid", 1'b0, resp_valid);
        check_flag("req_ready", 1'b1, req_ready);

        if (is_write && !misal) begin
            model_store(addr, size, wdata);
        end
        reqs_done++;
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure($sformatf("timeout: requests did not complete within %0d ns",
                                 WATCHDOG_NS));
    end

    initial begin
        int                r;
        int                r2;
        logic              is_write;
        logic              sgn;
        access_size_e      size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;

        seed       = 32'h7a53_6376;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        is_signed  = 1'b0;
        inst_size  = ACCESS_BYTE;
        address    = '0;
        write_data = '0;
        last_read  = '0;
        reqs_done  = 0;
        for (int i = 0; i < (1 << MODEL_AW); i++) begin
            model_mem[i] = 8'h00;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("req_ready", 1'b1, req_ready);
        check_flag("resp_valid", 1'b0, resp_valid);
        check_flag("resp_error", 1'b0, resp_error);
        check_data("read_data", '0, read_data);

        // Cleared RAM reads back as zero
        r    = $random(seed);
        addr = '0;
        addr[5:2] = r[3:0];
        run_request(1'b0, ACCESS_WORD, 1'b0, addr, '0);

        for (int i = 0; i < N_OPS; i++) begin
            r        = $random(seed);
            r2       = $random(seed);
            wdata    = $random(seed);
            is_write = r[0];
            size     = access_size_e'(r[2:1]);
            sgn      = r[3];
            addr     = '0;
            addr[5:0] = r2[13:8];

            if (r[15:8] < 26) begin
                // Roughly one in ten requests is forced off alignment
                if (size == ACCESS_BYTE) begin
                    size = ACCESS_HALF;
                end
                if (size != ACCESS_HALF && r[16]) begin
                    addr[1:0] = 2'b10;
                end else begin
                    addr[0] = 1'b1;
                end
            end else if (size == ACCESS_HALF) begin
                addr[0] = 1'b0;
            end else if (size != ACCESS_BYTE) begin
                addr[1:0] = 2'b00;
            end

            run_request(is_write, size, sgn, addr, wdata);

            // Whole-word readback shows neighbours untouched and errors harmless
            if (is_write || is_misaligned(size, addr)) begin
                run_request(1'b0, ACCESS_WORD, 1'b0, {addr[ADDR_W-1:2], 2'b00}, '0);
            end
        end

        $display("Completed %0d requests", reqs_done);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic                         is_signed,
    input  lsu_pkg::access_size_e        inst_size,
    input  logic [lsu_pkg::ADDR_W-1:0]   address,
    input  logic [lsu_pkg::DATA_W-1:0]   write_data,
    output logic                         req_ready,
    output logic                         resp_valid,
    output logic [lsu_pkg::DATA_W-1:0]   read_data,
    output logic                         resp_error
);
    import lsu_pkg::*;

    // Held request
    logic [ADDR_W-1:0] req_addr;
    access_size_e      req_size;
    logic              req_signed;
    logic              req_write;
    logic [DATA_W-1:0] req_wdata;
    logic              misaligned;
    logic              load_capture;

    // APB
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic              pready;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic [STRB_W-1:0] pstrb;

    apb_master_fsm u_apb_master_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .is_signed    (is_signed),
        .inst_size    (inst_size),
        .address      (address),
        .write_data   (write_data),
        .misaligned   (misaligned),
        .pready       (pready),
        .req_ready    (req_ready),
        .req_addr     (req_addr),
        .req_size     (req_size),
        .req_signed   (req_signed),
        .req_write    (req_write),
        .req_wdata    (req_wdata),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .load_capture (load_capture),
        .resp_valid   (resp_valid),
        .resp_error   (resp_error)
    );

    mem_stage u_mem_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_addr     (req_addr),
        .req_size     (req_size),
        .req_signed   (req_signed),
        .req_write    (req_write),
        .req_wdata    (req_wdata),
        .prdata       (prdata),
        .load_capture (load_capture),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .pstrb        (pstrb),
        .misaligned   (misaligned),
        .read_data    (read_data)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [lsu_pkg::ADDR_W-1:0]   paddr,
    input  logic [lsu_pkg::DATA_W-1:0]   pwdata,
    input  logic [lsu_pkg::STRB_W-1:0]   pstrb,
    output logic [lsu_pkg::DATA_W-1:0]   prdata,
    output logic                         pready
);
    import lsu_pkg::*;

    logic [DATA_W-1:0]      mem [MEM_DEPTH_WORDS];
    logic [MEM_INDEX_W-1:0] index;
    logic                   access;
    logic                   wr_en;

    // Upper address bits ignored, so the RAM wraps
    assign index  = paddr[MEM_INDEX_W+1:2];
    assign access = psel && penable;
    assign wr_en  = access && pready && pwrite;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (pstrb[b]) begin
                    mem[index][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

    assign prdata = access ? mem[index] : '0;

    wait_timer u_wait_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pready  (pready)
    );

    // A write that completes always touches at least one byte
    a_write_strobed: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (pstrb != '0)
    );

endmodule

// ==== src/apb_master_fsm.sv ====
`timescale 1ns/1ps

module apb_master_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic                         is_signed,
    input  lsu_pkg::access_size_e        inst_size,
    input  logic [lsu_pkg::ADDR_W-1:0]   address,
    input  logic [lsu_pkg::DATA_W-1:0]   write_data,
    input  logic                         misaligned,
    input  logic                         pready,
    output logic                         req_ready,
    output logic [lsu_pkg::ADDR_W-1:0]   req_addr,
    output lsu_pkg::access_size_e        req_size,
    output logic                         req_signed,
    output logic                         req_write,
    output logic [lsu_pkg::DATA_W-1:0]   req_wdata,
    output logic                         psel,
    output logic                         penable,
    output logic                         pwrite,
    output logic                         load_capture,
    output logic                         resp_valid,
    output logic                         resp_error
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP
    } state_e;

    state_e state;
    logic   accept;

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;

    // Request payload, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr   <= address;
            req_wdata  <= write_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            req_size   <= ACCESS_BYTE;
            req_signed <= 1'b0;
            req_write  <= 1'b0;
            resp_valid <= 1'b0;
            resp_error <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            resp_error <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        req_size   <= inst_size;
                        req_signed <= is_signed;
                        req_write  <= mem_write;
                        state      <= SETUP;
                    end
                end
                SETUP: begin
                    // Fields are registered now, so alignment is known here
                    if (misaligned) begin
                        resp_valid <= 1'b1;
                        resp_error <= 1'b1;
                        state      <= RESP;
                    end else begin
                        state      <= ACCESS;
                    end
                end
                ACCESS: begin
                    if (pready) begin
                        resp_valid <= 1'b1;
                        state      <= RESP;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // A misaligned request never raises psel
    assign psel         = (state == ACCESS) || ((state == SETUP) && !misaligned);
    assign penable      = (state == ACCESS);
    assign pwrite       = psel && req_write;
    assign load_capture = (state == ACCESS) && pready && !req_write;

    a_one_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> (mem_read ^ mem_write)
    );

    // Access phase is always entered from a selected setup cycle
    a_setup_first: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel)
    );

    // Transfer held steady while the slave inserts wait states
    a_access_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (penable && !pready) |=> (psel && penable && $stable(pwrite) && $stable(req_addr))
    );

endmodule

// ==== src/wait_timer.sv ====
`timescale 1ns/1ps

module wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic psel,
    input  logic penable,
    output logic pready
);
    import lsu_pkg::*;

    logic [WAIT_CNT_W-1:0] cnt;

    // Cleared in setup, then one count per access cycle without pready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (psel && !penable) begin
            cnt <= '0;
        end else if (psel && penable && !pready) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign pready = psel && penable && (cnt == WAIT_CNT_W'(MEM_WAIT_STATES));

    // Setup is followed by exactly MEM_WAIT_STATES stalled access cycles
    a_wait_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && !penable) |-> ##(MEM_WAIT_STATES + 1) (pready && psel && penable)
    );

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [lsu_pkg::ADDR_W-1:0]   req_addr,
    input  lsu_pkg::access_size_e        req_size,
    input  logic                         req_signed,
    input  logic                         req_write,
    input  logic [lsu_pkg::DATA_W-1:0]   req_wdata,
    input  logic [lsu_pkg::DATA_W-1:0]   prdata,
    input  logic                         load_capture,
    output logic [lsu_pkg::ADDR_W-1:0]   paddr,
    output logic [lsu_pkg::DATA_W-1:0]   pwdata,
    output logic [lsu_pkg::STRB_W-1:0]   pstrb,
    output logic                         misaligned,
    output logic [lsu_pkg::DATA_W-1:0]   read_data
);
    import lsu_pkg::*;

    logic [1:0]        offset;
    logic [DATA_W-1:0] lane_data;
    logic [DATA_W-1:0] load_ext;
    logic [DATA_W-1:0] store_data;
    logic [STRB_W-1:0] store_strb;

    assign offset = req_addr[1:0];
    assign paddr  = {req_addr[ADDR_W-1:2], 2'b00};

    // Halfword at odd address or word off a 4-byte boundary
    always_comb begin
        case (req_size)
            ACCESS_BYTE: misaligned = 1'b0;
            ACCESS_HALF: misaligned = offset[0];
            default:     misaligned = |offset;
        endcase
    end

    // Store side, data replicated across lanes and strobes pick the lane
    always_comb begin
        case (req_size)
            ACCESS_BYTE: begin
                store_data = {STRB_W{req_wdata[7:0]}};
                store_strb = STRB_W'(1) << offset;
            end
            ACCESS_HALF: begin
                store_data = {(STRB_W / 2){req_wdata[15:0]}};
                store_strb = STRB_W'(3) << {offset[1], 1'b0};
            end
            default: begin
                store_data = req_wdata;
                store_strb = '1;
            end
        endcase
    end

    assign pwdata = store_data;
    assign pstrb  = req_write ? store_strb : '0;

    // Load side, bring the addressed lane down to bit 0
    assign lane_data = prdata >> {offset, 3'b000};

    always_comb begin
        case (req_size)
            ACCESS_BYTE: load_ext = {{(DATA_W - 8){req_signed & lane_data[7]}}, lane_data[7:0]};
            ACCESS_HALF: load_ext = {{(DATA_W - 16){req_signed & lane_data[15]}},
                                     lane_data[15:0]};
            default:     load_ext = lane_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (load_capture) begin
            read_data <= load_ext;
        end
    end

    // The master only captures data for an aligned load
    a_capture_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_capture |-> (!req_write && !misaligned)
    );

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Access size code from the pipeline
    // Code 3 has no name and is handled as a word
    typedef enum logic [1:0] {
        ACCESS_BYTE = 2'd0,
        ACCESS_HALF = 2'd1,
        ACCESS_WORD = 2'd2
    } access_size_e;

    // Data RAM geometry, word index is address bits 9:2
    localparam int MEM_DEPTH_WORDS = 256;
    localparam int MEM_INDEX_W     = $clog2(MEM_DEPTH_WORDS);

    // Extra access-phase cycles before the RAM raises pready
    localparam int MEM_WAIT_STATES = 2;
    localparam int WAIT_CNT_W      = $clog2(MEM_WAIT_STATES + 2);

endpackage
